/* build.f */
+incdir+include
hdl/cbfp_pkg.sv
hdl/sc_fac_fifo.sv
hdl/index_sum.sv
hdl/block_shift.sv
hdl/cbfp2.sv
tb/cbfp2_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the cbfp2 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cbfp2_tb -f build.f

status=0
output=$(./obj_dir/Vcbfp2_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'test passed'; then
   exit 0
else
   echo "simulation exit status: $status"
   exit 1
fi

/* tb/cbfp2_tb.sv */
`timescale 1ns/1ps

`include "cbfp_settings.svh"

module cbfp2_tb import cbfp_pkg::*; ;

   localparam int CLK_PERIOD      = 100;
   localparam int N_ROWS          = 8;
   localparam int WATCHDOG_CYCLES = N_ROWS * 20 + 100;

   localparam int LANES = `CBFP_LANES;
   localparam int OUT_W = `CBFP_OUT_W;
   localparam int BLK_W = LANES * OUT_W;   // one packed output block
   localparam int PAD_W = 32 - OUT_W;

   localparam int FILL_RAND = 0;
   localparam int FILL_POS  = 1;
   localparam int FILL_NEG  = 2;

   // blk index, group 0..3 indices, fill mode
   int table_rows [N_ROWS][6] = '{
      '{ 0,  0,  3,  5,  8, FILL_RAND},   // left shift only
      '{ 4,  5,  5,  5,  5, FILL_POS},    // exactly 9 everywhere
      '{ 9,  0,  1,  6, 13, FILL_NEG},    // 9 up to 22
      '{12, 11, 12, 20, 31, FILL_POS},    // zero region
      '{ 2,  7,  8, 20, 21, FILL_RAND},   // 9, 10, 22, 23
      '{31, 31,  0,  0,  0, FILL_NEG},
      '{ 5,  1,  2,  3,  4, FILL_NEG},
      '{ 7,  3,  6,  9, 12, FILL_RAND}
   };

   logic          clk;
   logic          arst_n;
   logic          push_idx0;
   sc_fac_t       push_data_idx0;
   logic          push_idx1;
   sc_group_t     push_data_idx1;
   logic          pop;
   sample_lanes_t din_r;
   sample_lanes_t din_q;
   scaled_lanes_t dout_r;
   scaled_lanes_t dout_q;
   logic          dout_valid;
   logic          sc_ready;
   logic          sc_full;

   logic [31:0]      rng_state = 32'hbc0b_3da4;
   int               edge_cnt  = 0;
   logic [BLK_W-1:0] exp_r_q [$];
   logic [BLK_W-1:0] exp_q_q [$];
   int               exp_due_q [$];
   logic [BLK_W-1:0] mon_r;
   logic [BLK_W-1:0] mon_q;

   cbfp2 dut_i (
      .clk            (clk),
      .arst_n         (arst_n),
      .push_idx0      (push_idx0),
      .push_data_idx0 (push_data_idx0),
      .push_idx1      (push_idx1),
      .push_data_idx1 (push_data_idx1),
      .pop            (pop),
      .din_r          (din_r),
      .din_q          (din_q),
      .dout_r         (dout_r),
      .dout_q         (dout_q),
      .dout_valid     (dout_valid),
      .sc_ready       (sc_ready),
      .sc_full        (sc_full)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Expected output lane for sample smp and final index s
   function automatic logic [OUT_W-1:0] model_lane(input int smp, input int s);
      int v;
      if (s >= `CBFP_ZERO_LIMIT) begin
         v = 0;
      end else if (s > `CBFP_NORM_POINT) begin
         v = smp >>> (s - `CBFP_NORM_POINT);   // floor toward minus infinity
      end else begin
         v = smp << (`CBFP_NORM_POINT - s);
      end
      return v[OUT_W-1:0];
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic abort_run(input string reason);
      $display("t=%0t %s", $time, reason);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic push_row(input int row);
      push_idx0      = 1'b1;
      push_data_idx0 = sc_fac_t'(table_rows[row][0]);
      push_idx1      = 1'b1;
      for (int g = 0; g < `CBFP_GROUPS; g++) begin
         push_data_idx1[g] = sc_fac_t'(table_rows[row][1 + g]);
      end
      @(negedge clk);
      push_idx0 = 1'b0;
      push_idx1 = 1'b0;
   endtask

   // Drive one block with a pop and queue its expected result
   task automatic pop_row(input int row);
      logic [BLK_W-1:0] exp_r;
      logic [BLK_W-1:0] exp_q;
      int               s;
      check("sc_ready", 32'(sc_ready), 32'd1);
      for (int i = 0; i < LANES; i++) begin
         case (table_rows[row][5])
            FILL_POS: begin
               din_r[i] = 16'sh7fff;
               din_q[i] = 16'sh7fff;
            end
            FILL_NEG: begin
               din_r[i] = 16'sh8000;
               din_q[i] = 16'sh8000;
            end
            default: begin
               rng_state = xorshift32(rng_state);
               din_r[i]  = sample_t'(rng_state[15:0]);
               rng_state = xorshift32(rng_state);
               din_q[i]  = sample_t'(rng_state[15:0]);
            end
         endcase
         s = table_rows[row][0] + table_rows[row][1 + i / `CBFP_GROUP_LANES];
         exp_r[i*OUT_W +: OUT_W] = model_lane(int'(din_r[i]), s);
         exp_q[i*OUT_W +: OUT_W] = model_lane(int'(din_q[i]), s);
      end
      pop = 1'b1;
      exp_r_q.push_back(exp_r);
      exp_q_q.push_back(exp_q);
      exp_due_q.push_back(edge_cnt + 3);   // pop edge, shift edge, then visible
      @(negedge clk);
      pop = 1'b0;
   endtask

   task automatic pop_while_empty();
      check("sc_ready", 32'(sc_ready), 32'd0);
      pop = 1'b1;
      @(negedge clk);
      pop = 1'b0;
   endtask

   // Wait for all queued blocks, then a few quiet cycles
   task automatic drain();
      while (exp_due_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Output monitor
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      edge_cnt = edge_cnt + 1;
      if (dout_valid === 1'b1) begin
         if (exp_due_q.size() == 0) begin
            abort_run("dout_valid went high with no block pending");
         end else begin
            check("dout_valid edge", edge_cnt, exp_due_q.pop_front());
            mon_r = exp_r_q.pop_front();
            mon_q = exp_q_q.pop_front();
            for (int i = 0; i < LANES; i++) begin
               check($sformatf("dout_r[%0d]", i), {{PAD_W{1'b0}}, dout_r[i]},
                     {{PAD_W{1'b0}}, mon_r[i*OUT_W +: OUT_W]});
               check($sformatf("dout_q[%0d]", i), {{PAD_W{1'b0}}, dout_q[i]},
                     {{PAD_W{1'b0}}, mon_q[i*OUT_W +: OUT_W]});
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d clock periods", WATCHDOG_CYCLES);
      $display("test failed");
      $fatal(1);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      arst_n         = 1'b0;
      push_idx0      = 1'b0;
      push_data_idx0 = '0;
      push_idx1      = 1'b0;
      push_data_idx1 = '0;
      pop            = 1'b0;
      for (int i = 0; i < LANES; i++) begin
         din_r[i] = '0;
         din_q[i] = '0;
      end
      repeat (3) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // Idle after reset, pop with empty queues
      check("dout_valid", 32'(dout_valid), 32'd0);
      check("sc_ready", 32'(sc_ready), 32'd0);
      check("sc_full", 32'(sc_full), 32'd0);
      pop_while_empty();
      drain();

      // One block at a time
      for (int r = 0; r < N_ROWS; r++) begin
         push_row(r);
         pop_row(r);
         drain();
         check("sc_ready", 32'(sc_ready), 32'd0);
      end

      // Whole table queued, then back to back pops
      for (int r = 0; r < N_ROWS; r++) begin
         push_row(r);
      end
      for (int r = 0; r < N_ROWS; r++) begin
         pop_row(r);
      end
      check("sc_ready", 32'(sc_ready), 32'd0);
      drain();

      // Fill both queues, then one push too many
      for (int r = 0; r < `CBFP_FIFO_DEPTH; r++) begin
         check("sc_full", 32'(sc_full), 32'd0);
         push_row(r % N_ROWS);
      end
      check("sc_full", 32'(sc_full), 32'd1);
      push_row(5);   // dropped
      check("sc_full", 32'(sc_full), 32'd1);
      for (int r = 0; r < `CBFP_FIFO_DEPTH; r++) begin
         pop_row(r % N_ROWS);
      end
      check("sc_ready", 32'(sc_ready), 32'd0);
      check("sc_full", 32'(sc_full), 32'd0);
      pop_while_empty();
      drain();

      $display("test passed");
      $finish;
   end

endmodule

/* hdl/cbfp2.sv */
`timescale 1ns/1ps

`include "cbfp_settings.svh"

module cbfp2 import cbfp_pkg::*; (
   input  logic          clk,
   input  logic          arst_n,

   // Index pushes from the earlier stages
   input  logic          push_idx0,
   input  sc_fac_t       push_data_idx0,
   input  logic          push_idx1,
   input  sc_group_t     push_data_idx1,

   // Block from the FFT
   input  logic          pop,
   input  sample_lanes_t din_r,
   input  sample_lanes_t din_q,

   output scaled_lanes_t dout_r,
   output scaled_lanes_t dout_q,
   output logic          dout_valid,

   output logic          sc_ready,
   output logic          sc_full
);

   sc_fac_t      blk_head;
   sc_group_t    grp_head;
   logic         blk_full;
   logic         blk_empty;
   logic         grp_full;
   logic         grp_empty;

   logic         pop_ok;
   final_lanes_t fac_final;
   logic         fac_valid;

   // Both indices must be present for a block
   assign sc_ready = ~blk_empty & ~grp_empty;
   assign sc_full  = blk_full | grp_full;
   assign pop_ok   = pop & sc_ready;   // unqualified pops are ignored

   ////////////////////////////////////////////////////////////////////////////
   // Index queues
   ////////////////////////////////////////////////////////////////////////////

   sc_fac_fifo #(
      .payload_t (sc_fac_t),
      .DEPTH     (`CBFP_FIFO_DEPTH)
   ) blk_fifo_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (push_idx0),
      .push_data (push_data_idx0),
      .pop       (pop_ok),
      .head      (blk_head),
      .full      (blk_full),
      .empty     (blk_empty)
   );

   sc_fac_fifo #(
      .payload_t (sc_group_t),
      .DEPTH     (`CBFP_FIFO_DEPTH)
   ) grp_fifo_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (push_idx1),
      .push_data (push_data_idx1),
      .pop       (pop_ok),
      .head      (grp_head),
      .full      (grp_full),
      .empty     (grp_empty)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////////////////////

   index_sum index_sum_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .load      (pop_ok),
      .blk_fac   (blk_head),
      .grp_fac   (grp_head),
      .fac_final (fac_final),
      .fac_valid (fac_valid)
   );

   // Samples captured on the pop edge, shifted one edge later
   block_shift block_shift_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .capture    (pop_ok),
      .din_r      (din_r),
      .din_q      (din_q),
      .fac_final  (fac_final),
      .fac_valid  (fac_valid),
      .dout_r     (dout_r),
      .dout_q     (dout_q),
      .dout_valid (dout_valid)
   );

endmodule

/* hdl/block_shift.sv */
`timescale 1ns/1ps

`include "cbfp_settings.svh"

module block_shift import cbfp_pkg::*; (
   input  logic          clk,
   input  logic          arst_n,

   input  logic          capture,
   input  sample_lanes_t din_r,
   input  sample_lanes_t din_q,

   input  final_lanes_t  fac_final,
   input  logic          fac_valid,

   output scaled_lanes_t dout_r,
   output scaled_lanes_t dout_q,
   output logic          dout_valid
);

   sample_lanes_t cap_r;
   sample_lanes_t cap_q;

   // Renormalize one sample to the output width
   function automatic scaled_t renorm(input sample_t smp, input final_fac_t s);
      sample_t shifted;
      if (s >= `CBFP_ZERO_LIMIT) begin
         shifted = '0;
      end else if (s > `CBFP_NORM_POINT) begin
         shifted = smp >>> (s - `CBFP_NORM_POINT);   // sign kept
      end else begin
         shifted = smp <<< (`CBFP_NORM_POINT - s);
      end
      return scaled_t'(shifted);   // low bits only
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Sample capture, same edge as the index sum
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (capture) begin
         cap_r <= din_r;
         cap_q <= din_q;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (fac_valid) begin
         for (int i = 0; i < `CBFP_LANES; i++) begin
            dout_r[i] <= renorm(cap_r[i], fac_final[i]);
            dout_q[i] <= renorm(cap_q[i], fac_final[i]);
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dout_valid <= 1'b0;
      end else begin
         dout_valid <= fac_valid;
      end
   end

endmodule

/* hdl/index_sum.sv */
`timescale 1ns/1ps

`include "cbfp_settings.svh"

module index_sum import cbfp_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,

   input  logic         load,
   input  sc_fac_t      blk_fac,
   input  sc_group_t    grp_fac,

   output final_lanes_t fac_final,
   output logic         fac_valid
);

   final_lanes_t lane_sum;

   // Block index plus the group index covering each lane
   always_comb begin
      for (int i = 0; i < `CBFP_LANES; i++) begin
         lane_sum[i] = final_fac_t'(blk_fac)
                     + final_fac_t'(grp_fac[i / `CBFP_GROUP_LANES]);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Final index register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (load) begin
         fac_final <= lane_sum;   // held until next pop
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fac_valid <= 1'b0;
      end else begin
         fac_valid <= load;   // one cycle strobe
      end
   end

endmodule

/* hdl/sc_fac_fifo.sv */
`timescale 1ns/1ps

`include "cbfp_settings.svh"

module sc_fac_fifo import cbfp_pkg::*; #(
   parameter type payload_t = sc_fac_t,
   parameter int  DEPTH     = `CBFP_FIFO_DEPTH
) (
   input  logic     clk,
   input  logic     arst_n,

   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,

   output payload_t head,
   output logic     full,
   output logic     empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t           mem [DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;

   logic do_push;
   logic do_pop;

   // Overflow and underflow are silently dropped
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   assign head = mem[rd_ptr];   // fall-through, oldest entry

   ////////////////////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else begin
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or simultaneous push and pop
         endcase
      end
   end

endmodule

/* hdl/cbfp_pkg.sv */
`include "cbfp_settings.svh"

package cbfp_pkg;

   // Scaling index from the first stage
   typedef logic [`CBFP_FAC_W-1:0] sc_fac_t;

   // Second stage group, entry 0 covers lanes 0 to 7
   typedef sc_fac_t [`CBFP_GROUPS-1:0] sc_group_t;

   typedef logic [`CBFP_FINAL_W-1:0] final_fac_t;   // summed index

   // Samples before and after renormalization
   typedef logic signed [`CBFP_IN_W-1:0]  sample_t;
   typedef logic signed [`CBFP_OUT_W-1:0] scaled_t;

   ////////////////////////////////////////////////////////////////////////////
   // Per-lane arrays, lane 0 first
   ////////////////////////////////////////////////////////////////////////////

   typedef sample_t    sample_lanes_t [`CBFP_LANES];
   typedef scaled_t    scaled_lanes_t [`CBFP_LANES];
   typedef final_fac_t final_lanes_t  [`CBFP_LANES];

endpackage

/* include/cbfp_settings.svh */
`ifndef CBFP_SETTINGS_SVH
`define CBFP_SETTINGS_SVH

// Block geometry
`define CBFP_LANES        32
`define CBFP_GROUPS       4
`define CBFP_GROUP_LANES  8    // lanes per group index

// Index widths
`define CBFP_FAC_W        5
`define CBFP_FINAL_W      6    // sum of two 5 bit indices

// Sample widths
`define CBFP_IN_W         16
`define CBFP_OUT_W        13

// Renormalization limits
`define CBFP_NORM_POINT   9    // no shift at this index
`define CBFP_ZERO_LIMIT   23   // output forced to zero from here

// Index queue depth
`define CBFP_FIFO_DEPTH   8

`endif
